// File: dcache_top.f
hw/dcache_pkg.sv
hw/lookup_if.sv
hw/set_array.sv
hw/cache_ways.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
sim/tb_clock.sv
sim/dcache_sva.sv
sim/dcache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the cache testbench with Verilator, run it, and search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb \
  -f dcache_top.f -o vsim \
  && ./obj_dir/vsim +verilator+error+limit+1000 2>&1 | tee sim.log
grep -q "^No errors$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: sim/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
  import dcache_pkg::*;

  localparam int          WAYS     = 6;
  localparam int          LIMIT    = 1000;          // Cycles per wait
  localparam logic [31:0] SEED     = 32'h797f951c;
  localparam logic [23:0] TAG_BASE = 24'h51a200;    // Nine random tags from here
  localparam logic [23:0] LRU_TAG  = 24'h7c3e00;
  localparam logic [2:0]  SET_OF [3] = '{3'd1, 3'd4, 3'd6};

  logic clk, rst;
  logic cpu_req_valid, cpu_req_write, cpu_req_ready, cpu_rsp_valid, cpu_rsp_ready;
  addr_t cpu_req_addr;
  word_t cpu_req_wdata, cpu_rsp_data;
  strb_t cpu_req_wstrb;
  logic  mem_rd_req_valid, mem_rd_rsp_ready, mem_wr_req_valid, mem_wr_data_valid;
  logic  mem_wr_data_last;
  addr_t mem_rd_req_addr, mem_wr_req_addr;
  word_t mem_wr_data;
  logic  mem_rd_req_ready = 1'b0;
  logic  mem_rd_rsp_valid = 1'b0;
  logic  mem_rd_rsp_last  = 1'b0;
  word_t mem_rd_rsp_data  = '0;
  logic  mem_wr_req_ready = 1'b0;
  logic  mem_wr_data_ready = 1'b0;

  word_t       backing [addr_t];   // Memory behind the cache
  word_t       shadow  [addr_t];   // What the CPU should read
  logic [31:0] cpu_state = SEED;
  logic [31:0] mem_state = ~SEED;
  int          errors = 0;
  int          timeouts = 0;
  int          rd_reqs, wr_reqs;   // Handshakes during one CPU access
  int          rd_beat, wr_beat;
  logic        rd_busy, wr_busy;
  addr_t       rd_addr_seen, wr_addr_seen;

  // Reference cache state, per set and way
  logic        m_valid [NUM_SETS][WAYS];
  logic        m_dirty [NUM_SETS][WAYS];
  logic [23:0] m_tag   [NUM_SETS][WAYS];
  int unsigned m_stamp [NUM_SETS][WAYS];
  int unsigned m_time = 1;         // Above the reset stamp of 0

  tb_clock u_clock (.clk(clk), .rst(rst));

  dcache_top #(.NUM_WAYS(WAYS)) uut (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] cpu_rand();
    cpu_state = xorshift32(cpu_state);
    return cpu_state;
  endfunction

  function automatic logic [31:0] mem_rand();
    mem_state = xorshift32(mem_state);
    return mem_state;
  endfunction

  function automatic word_t backing_word(input addr_t a);
    return backing.exists(a) ? backing[a] : xorshift32(a);  // Unwritten words
  endfunction

  function automatic word_t shadow_word(input addr_t a);
    return shadow.exists(a) ? shadow[a] : xorshift32(a);
  endfunction

  function automatic word_t merge_bytes(input word_t old, input word_t d, input strb_t s);
    word_t m;
    m = old;
    for (int b = 0; b < 4; b++) begin
      if (s[b]) m[8*b +: 8] = d[8*b +: 8];
    end
    return m;
  endfunction

  function automatic addr_t lru_addr(input int k);
    return {LRU_TAG + 24'(k), 3'd2, 3'(k), 2'b00};  // All in set 2
  endfunction

  // Hit on lowest matching way, else evict oldest stamp; both end stamped
  task automatic model_access(input addr_t a, input logic wr,
                              output logic miss, output logic wb, output addr_t wb_a);
    int          s, hw;
    logic [23:0] t;
    s    = int'(a[7:5]);
    t    = a[31:8];
    hw   = -1;
    wb   = 1'b0;
    wb_a = '0;
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (m_valid[s][w] && m_tag[s][w] == t) hw = w;
    end
    miss = (hw < 0);
    if (miss) begin
      hw = 0;
      for (int w = 1; w < WAYS; w++) begin
        if (m_stamp[s][w] < m_stamp[s][hw]) hw = w;  // Ties keep lower way
      end
      wb   = m_valid[s][hw] && m_dirty[s][hw];
      wb_a = {m_tag[s][hw], 3'(s), 5'd0};
      m_valid[s][hw] = 1'b1;
      m_dirty[s][hw] = 1'b0;
      m_tag[s][hw]   = t;
    end
    m_stamp[s][hw] = m_time;
    if (m_time != '1) m_time++;
    if (wr) m_dirty[s][hw] = 1'b1;
  endtask

  // Starts and ends on a falling edge
  task automatic cpu_access(input addr_t a, input logic wr, input word_t d, input strb_t s,
                            output int nrd);
    logic  miss, wb;
    addr_t wb_a;
    word_t want;
    int    n;
    nrd = 0;
    if (timeouts != 0) return;
    model_access(a, wr, miss, wb, wb_a);
    rd_reqs = 0;
    wr_reqs = 0;
    cpu_req_valid = 1'b1;
    cpu_req_write = wr;
    cpu_req_addr  = a;
    cpu_req_wdata = d;
    cpu_req_wstrb = s;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!cpu_req_ready && n < LIMIT);
    if (!cpu_req_ready) begin
      timeouts++;
      $display("Timeout waiting for cpu_req_ready at address %h", a);
      cpu_req_valid = 1'b0;
      return;
    end
    want = shadow_word(a);
    if (wr) shadow[a] = merge_bytes(want, d, s);  // Lands on the coming edge
    @(negedge clk);
    cpu_req_valid = 1'b0;
    if (!wr) begin
      n = 0;
      cpu_rsp_ready = (cpu_rand() & 3) != 0;
      while (!(cpu_rsp_valid && cpu_rsp_ready) && n < LIMIT) begin
        @(negedge clk);
        n++;
        cpu_rsp_ready = (cpu_rand() & 3) != 0;  // Random back-pressure
      end
      if (!(cpu_rsp_valid && cpu_rsp_ready)) begin
        timeouts++;
        $display("Timeout waiting for cpu_rsp_valid at address %h", a);
        return;
      end
      assert (cpu_rsp_data == want) else begin
        errors++;
        $display("FAIL cpu_rsp_data addr=%h got=%h exp=%h", a, cpu_rsp_data, want);
      end
      @(negedge clk);
      cpu_rsp_ready = 1'b0;
    end
    nrd = rd_reqs;
    assert (rd_reqs == int'(miss) && wr_reqs == int'(wb)) else begin
      errors++;
      $display("Address %h caused %0d refills and %0d write-backs, expected %0d and %0d",
               a, rd_reqs, wr_reqs, miss, wb);
    end
    assert (!miss || rd_addr_seen == {a[31:5], 5'd0}) else begin
      errors++;
      $display("FAIL mem_rd_req_addr got=%h exp=%h", rd_addr_seen, {a[31:5], 5'd0});
    end
    assert (!wb || wr_addr_seen == wb_a) else begin
      errors++;
      $display("FAIL mem_wr_req_addr got=%h exp=%h", wr_addr_seen, wb_a);
    end
  endtask

  task automatic read_expect_refill(input int k, input int want_rd);
    int nrd;
    cpu_access(lru_addr(k), 1'b0, '0, '0, nrd);
    assert (timeouts != 0 || nrd == want_rd) else begin
      errors++;
      $display("LRU order broken, line %0d gave %0d refills instead of %0d", k, nrd, want_rd);
    end
  endtask

  // Burst memory, answers one beat at a time with random stalls
  always @(negedge clk) begin : memory_model
    logic [31:0] r;
    addr_t       wa;
    r = mem_rand();
    if (rst) begin
      rd_busy = 1'b0;
      wr_busy = 1'b0;
    end else begin
      mem_rd_rsp_valid = 1'b0;
      mem_rd_rsp_last  = 1'b0;
      if (rd_busy && mem_rd_rsp_ready && r[1:0] != 2'b00) begin
        mem_rd_rsp_valid = 1'b1;
        mem_rd_rsp_data  = backing_word(rd_addr_seen + 32'(4 * rd_beat));
        mem_rd_rsp_last  = (rd_beat == LINE_WORDS - 1);
        rd_beat++;
        rd_busy = (rd_beat < LINE_WORDS);
      end
      mem_rd_req_ready = r[2] | r[3];
      if (mem_rd_req_valid && mem_rd_req_ready) begin
        rd_busy      = 1'b1;
        rd_beat      = 0;
        rd_addr_seen = mem_rd_req_addr;
        rd_reqs++;
      end
      mem_wr_data_ready = r[4] | r[5];
      if (wr_busy && mem_wr_data_valid && mem_wr_data_ready) begin
        wa = wr_addr_seen + 32'(4 * wr_beat);
        assert (mem_wr_data == shadow_word(wa)) else begin
          errors++;
          $display("FAIL mem_wr_data addr=%h got=%h exp=%h", wa, mem_wr_data, shadow_word(wa));
        end
        backing[wa] = mem_wr_data;
        wr_beat++;
        wr_busy = (wr_beat < LINE_WORDS);
      end
      mem_wr_req_ready = r[6] | r[7];
      if (mem_wr_req_valid && mem_wr_req_ready) begin
        wr_busy      = 1'b1;
        wr_beat      = 0;
        wr_addr_seen = mem_wr_req_addr;
        wr_reqs++;
      end
    end
  end

  initial begin : stimulus
    logic [31:0] r;
    addr_t       a;
    int          n, nrd;
    int          read_order [6] = '{3, 0, 5, 1, 4, 2};
    cpu_req_valid = 1'b0;
    cpu_req_write = 1'b0;
    cpu_req_addr  = '0;
    cpu_req_wdata = '0;
    cpu_req_wstrb = '0;
    cpu_rsp_ready = 1'b0;
    for (int s = 0; s < NUM_SETS; s++) begin
      for (int w = 0; w < WAYS; w++) begin
        m_valid[s][w] = 1'b0;
        m_dirty[s][w] = 1'b0;
        m_tag[s][w]   = '0;
        m_stamp[s][w] = 0;
      end
    end
    n = 0;
    while (rst !== 1'b0 && n < LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (rst !== 1'b0) begin
      timeouts++;
      $display("Timeout waiting for reset release");
    end
    repeat (4) begin
      @(negedge clk);
      assert (!(cpu_req_ready || cpu_rsp_valid || mem_rd_req_valid || mem_wr_req_valid ||
                mem_wr_data_valid)) else begin
        errors++;
        $display("A valid or ready output went high before the first request");
      end
    end
    // Three sets, nine tags each, so lines get evicted dirty and clean
    for (int i = 0; i < 400 && timeouts == 0; i++) begin
      r = cpu_rand();
      a = {TAG_BASE + 24'(r[7:0] % 9), SET_OF[r[9:8] % 3], r[12:10], 2'b00};
      cpu_access(a, r[13], cpu_rand(), r[17:14], nrd);
    end
    // Fill set 2, age it in a known order, then force one eviction
    for (int k = 0; k < 6; k++) read_expect_refill(k, 1);
    for (int j = 0; j < 6; j++) read_expect_refill(read_order[j], 0);
    read_expect_refill(6, 1);
    for (int j = 1; j < 6; j++) read_expect_refill(read_order[j], 0);
    read_expect_refill(read_order[0], 1);
    $display("Check failures: %0d, assertion failures: %0d, timeouts: %0d",
             errors, uut.u_sva.sva_errors, timeouts);
    if (errors == 0 && uut.u_sva.sva_errors == 0 && timeouts == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/dcache_sva.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_sva (
  input logic              clk,
  input logic              rst,
  input logic              cpu_rsp_valid,
  input logic              cpu_rsp_ready,
  input dcache_pkg::word_t cpu_rsp_data,
  input logic              mem_rd_req_valid,
  input dcache_pkg::addr_t mem_rd_req_addr,
  input logic              mem_rd_req_ready,
  input logic              mem_wr_req_valid,
  input dcache_pkg::addr_t mem_wr_req_addr,
  input logic              mem_wr_req_ready,
  input logic              mem_wr_data_valid,
  input dcache_pkg::word_t mem_wr_data,
  input logic              mem_wr_data_last,
  input logic              mem_wr_data_ready
);

  int sva_errors = 0;  // Failure count, read from the testbench top
  int wr_beats;        // Accepted beats of the open write burst

  always_ff @(posedge clk) begin
    if (rst) wr_beats <= 0;
    else if (mem_wr_data_valid && mem_wr_data_ready) wr_beats <= mem_wr_data_last ? 0 : wr_beats + 1;
  end

  // Burst addresses sit on a 32-byte line boundary
  a_align: assert property (@(posedge clk) disable iff (rst)
    (mem_rd_req_valid -> mem_rd_req_addr[4:0] == 5'd0) &&
    (mem_wr_req_valid -> mem_wr_req_addr[4:0] == 5'd0))
    else begin sva_errors++; $error("memory request address not line aligned"); end

  a_last: assert property (@(posedge clk) disable iff (rst)
    mem_wr_data_valid |-> (mem_wr_data_last == (wr_beats == 7)))
    else begin sva_errors++; $error("write burst last flag on the wrong beat"); end

  // A new request only after the previous write burst closed with last
  a_burst_done: assert property (@(posedge clk) disable iff (rst)
    (mem_wr_req_valid || mem_rd_req_valid) |-> (wr_beats == 0))
    else begin sva_errors++; $error("write burst not complete before next request"); end

  a_rd_hold: assert property (@(posedge clk) disable iff (rst)
    mem_rd_req_valid && !mem_rd_req_ready |=> mem_rd_req_valid && $stable(mem_rd_req_addr))
    else begin sva_errors++; $error("read request dropped before ready"); end

  a_wr_hold: assert property (@(posedge clk) disable iff (rst)
    mem_wr_req_valid && !mem_wr_req_ready |=> mem_wr_req_valid && $stable(mem_wr_req_addr))
    else begin sva_errors++; $error("write request dropped before ready"); end

  a_wd_hold: assert property (@(posedge clk) disable iff (rst)
    mem_wr_data_valid && !mem_wr_data_ready |=>
      mem_wr_data_valid && $stable(mem_wr_data) && $stable(mem_wr_data_last))
    else begin sva_errors++; $error("write beat changed before ready"); end

  a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
    cpu_rsp_valid && !cpu_rsp_ready |=> cpu_rsp_valid && $stable(cpu_rsp_data))
    else begin sva_errors++; $error("CPU response dropped before ready"); end

endmodule

bind dcache_top dcache_sva u_sva (.*);

`default_nettype wire

// File: sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int HALF_NS      = 20,  // 40 ns period
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

  // Held over two rising edges, released on a falling edge like other inputs
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: hw/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
  parameter int NUM_WAYS = 6
) (
  input  logic              clk,
  input  logic              rst,
  // CPU request and response
  input  logic              cpu_req_valid,
  input  logic              cpu_req_write,
  input  dcache_pkg::addr_t cpu_req_addr,
  input  dcache_pkg::word_t cpu_req_wdata,
  input  dcache_pkg::strb_t cpu_req_wstrb,
  output logic              cpu_req_ready,
  output logic              cpu_rsp_valid,
  output dcache_pkg::word_t cpu_rsp_data,
  input  logic              cpu_rsp_ready,
  // Memory read, always eight-beat bursts
  output logic              mem_rd_req_valid,
  output dcache_pkg::addr_t mem_rd_req_addr,
  input  logic              mem_rd_req_ready,
  input  logic              mem_rd_rsp_valid,
  input  dcache_pkg::word_t mem_rd_rsp_data,
  input  logic              mem_rd_rsp_last,
  output logic              mem_rd_rsp_ready,
  // Memory write, full-word beats
  output logic              mem_wr_req_valid,
  output dcache_pkg::addr_t mem_wr_req_addr,
  input  logic              mem_wr_req_ready,
  output logic              mem_wr_data_valid,
  output dcache_pkg::word_t mem_wr_data,
  output logic              mem_wr_data_last,
  input  logic              mem_wr_data_ready
);

  lookup_if #(.NUM_WAYS(NUM_WAYS)) lk ();

  dcache_ctrl #(.NUM_WAYS(NUM_WAYS)) u_ctrl (
    .clk               (clk),
    .rst               (rst),
    .cpu_req_valid     (cpu_req_valid),
    .cpu_req_write     (cpu_req_write),
    .cpu_req_addr      (cpu_req_addr),
    .cpu_req_ready     (cpu_req_ready),
    .cpu_rsp_valid     (cpu_rsp_valid),
    .cpu_rsp_data      (cpu_rsp_data),
    .cpu_rsp_ready     (cpu_rsp_ready),
    .mem_rd_req_valid  (mem_rd_req_valid),
    .mem_rd_req_addr   (mem_rd_req_addr),
    .mem_rd_req_ready  (mem_rd_req_ready),
    .mem_rd_rsp_valid  (mem_rd_rsp_valid),
    .mem_rd_rsp_data   (mem_rd_rsp_data),
    .mem_rd_rsp_last   (mem_rd_rsp_last),
    .mem_rd_rsp_ready  (mem_rd_rsp_ready),
    .mem_wr_req_valid  (mem_wr_req_valid),
    .mem_wr_req_addr   (mem_wr_req_addr),
    .mem_wr_req_ready  (mem_wr_req_ready),
    .mem_wr_data_valid (mem_wr_data_valid),
    .mem_wr_data       (mem_wr_data),
    .mem_wr_data_last  (mem_wr_data_last),
    .mem_wr_data_ready (mem_wr_data_ready),
    .lk                (lk.ctrl)
  );

  // Storage and lookup, addressed by the held CPU request
  cache_ways #(.NUM_WAYS(NUM_WAYS)) u_ways (
    .clk       (clk),
    .rst       (rst),
    .req_addr  (cpu_req_addr),
    .req_wdata (cpu_req_wdata),
    .req_wstrb (cpu_req_wstrb),
    .lk        (lk.ways)
  );

endmodule

`default_nettype wire

// File: hw/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
  parameter int NUM_WAYS = 6
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              cpu_req_valid,
  input  logic              cpu_req_write,
  input  dcache_pkg::addr_t cpu_req_addr,
  output logic              cpu_req_ready,
  output logic              cpu_rsp_valid,
  output dcache_pkg::word_t cpu_rsp_data,
  input  logic              cpu_rsp_ready,
  output logic              mem_rd_req_valid,
  output dcache_pkg::addr_t mem_rd_req_addr,
  input  logic              mem_rd_req_ready,
  input  logic              mem_rd_rsp_valid,
  input  dcache_pkg::word_t mem_rd_rsp_data,
  input  logic              mem_rd_rsp_last,
  output logic              mem_rd_rsp_ready,
  output logic              mem_wr_req_valid,
  output dcache_pkg::addr_t mem_wr_req_addr,
  input  logic              mem_wr_req_ready,
  output logic              mem_wr_data_valid,
  output dcache_pkg::word_t mem_wr_data,
  output logic              mem_wr_data_last,
  input  logic              mem_wr_data_ready,
  lookup_if.ctrl            lk
);
  import dcache_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE, S_WB_REQ, S_WB_DATA, S_RF_REQ, S_REFILL, S_RD_HIT, S_WR_HIT, S_RESP
  } state_t;

  state_t                        state_q, state_d;
  stamp_t                        stamp_q;   // LRU time
  logic [$clog2(LINE_WORDS)-1:0] beat_q;    // Write-back beat
  line_t                         wb_q;      // Victim line being drained
  word_t                         rsp_q;
  logic [WORD_SEL_W-1:0]         wsel;
  set_idx_t                      idx;

  // Way-index widths below 1 bit or above 3 bits are not supported
  if (NUM_WAYS < 2 || NUM_WAYS > 8) begin : g_bad_ways
    $error("dcache_ctrl supports 2 to 8 ways");
  end

  assign wsel = cpu_req_addr[2 +: WORD_SEL_W];
  assign idx  = cpu_req_addr[OFFSET_W +: INDEX_W];

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (cpu_req_valid) begin
          if (lk.hit) state_d = cpu_req_write ? S_WR_HIT : S_RD_HIT;
          else        state_d = lk.victim_dirty ? S_WB_REQ : S_RF_REQ;
        end
      end
      S_WB_REQ:  if (mem_wr_req_ready) state_d = S_WB_DATA;
      S_WB_DATA: if (mem_wr_data_ready && mem_wr_data_last) state_d = S_RF_REQ;
      S_RF_REQ:  if (mem_rd_req_ready) state_d = S_REFILL;
      S_REFILL: begin
        if (mem_rd_rsp_valid && mem_rd_rsp_last) begin
          state_d = cpu_req_write ? S_WR_HIT : S_RD_HIT;  // Replay as a hit
        end
      end
      S_RD_HIT:  state_d = S_RESP;
      S_WR_HIT:  state_d = S_IDLE;
      S_RESP:    if (cpu_rsp_ready) state_d = S_IDLE;
      default:   state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) state_q <= S_IDLE;
    else     state_q <= state_d;
  end

  // Starts at 1 so a touched way always beats a never-used one
  always_ff @(posedge clk) begin
    if (rst) begin
      stamp_q <= stamp_t'(1);
    end else if (lk.touch && (stamp_q != '1)) begin
      stamp_q <= stamp_q + 1'b1;  // Saturates
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      beat_q <= '0;
    end else if (state_q == S_WB_REQ && mem_wr_req_ready) begin
      beat_q <= '0;
    end else if (state_q == S_WB_DATA && mem_wr_data_ready) begin
      beat_q <= beat_q + 1'b1;    // Wraps after the eighth beat
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_WB_REQ && mem_wr_req_ready) begin
      wb_q <= lk.victim_line;
    end else if (state_q == S_WB_DATA && mem_wr_data_ready) begin
      wb_q <= wb_q >> $bits(word_t);  // Next word to the bottom
    end
  end

  // CPU may change the address once ready is seen, so latch the word here
  always_ff @(posedge clk) begin
    if (state_q == S_RD_HIT) rsp_q <= lk.hit_line[wsel*$bits(word_t) +: $bits(word_t)];
  end

  assign cpu_req_ready = (state_q == S_RD_HIT) || (state_q == S_WR_HIT);  // One-cycle pulse
  assign cpu_rsp_valid = (state_q == S_RESP);
  assign cpu_rsp_data  = rsp_q;

  assign mem_wr_req_valid  = (state_q == S_WB_REQ);
  assign mem_wr_req_addr   = {lk.victim_tag, idx, OFFSET_W'(0)};  // Victim line base
  assign mem_wr_data_valid = (state_q == S_WB_DATA);
  assign mem_wr_data       = wb_q[$bits(word_t)-1:0];
  assign mem_wr_data_last  = (state_q == S_WB_DATA) && (beat_q == LINE_WORDS - 1);

  assign mem_rd_req_valid  = (state_q == S_RF_REQ);
  assign mem_rd_req_addr   = {cpu_req_addr[31:OFFSET_W], OFFSET_W'(0)};  // Line aligned
  assign mem_rd_rsp_ready  = (state_q == S_REFILL);

  assign lk.touch       = cpu_req_ready;  // Both hit states refresh LRU
  assign lk.write_hit   = (state_q == S_WR_HIT);
  assign lk.refill_beat = (state_q == S_REFILL) && mem_rd_rsp_valid;
  assign lk.refill_done = lk.refill_beat && mem_rd_rsp_last;
  assign lk.refill_data = mem_rd_rsp_data;
  assign lk.stamp       = stamp_q;

endmodule

`default_nettype wire

// File: hw/cache_ways.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ways #(
  parameter int NUM_WAYS = 6
) (
  input  logic              clk,
  input  logic              rst,
  input  dcache_pkg::addr_t req_addr,
  input  dcache_pkg::word_t req_wdata,
  input  dcache_pkg::strb_t req_wstrb,
  lookup_if.ways            lk
);
  import dcache_pkg::*;

  localparam int WAY_W  = $clog2(NUM_WAYS);
  localparam int WORD_W = $bits(word_t);

  set_idx_t              idx;
  tag_t                  tag;
  logic [WORD_SEL_W-1:0] wsel;

  meta_t  meta_rd  [NUM_WAYS];
  line_t  line_rd  [NUM_WAYS];
  stamp_t stamp_rd [NUM_WAYS];

  logic [NUM_WAYS-1:0] way_hit;
  logic [NUM_WAYS-1:0] line_wen;   // Meta and line share this enable
  logic [NUM_WAYS-1:0] stamp_wen;
  logic [WAY_W-1:0]    hit_idx;
  logic [WAY_W-1:0]    vic_idx;
  stamp_t              vic_stamp;

  word_t old_word, bit_mask, merged_word;
  line_t merged_line, shifted_line, line_wdata;
  meta_t meta_wdata;

  assign idx  = req_addr[OFFSET_W +: INDEX_W];
  assign tag  = req_addr[OFFSET_W + INDEX_W +: TAG_W];
  assign wsel = req_addr[2 +: WORD_SEL_W];  // Word inside the line

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    set_array #(.entry_t(meta_t), .NUM_SETS(NUM_SETS)) u_meta (
      .clk(clk), .rst(rst), .wen(line_wen[w]), .waddr(idx),
      .wdata(meta_wdata), .raddr(idx), .rdata(meta_rd[w])
    );
    set_array #(.entry_t(line_t), .NUM_SETS(NUM_SETS)) u_line (
      .clk(clk), .rst(rst), .wen(line_wen[w]), .waddr(idx),
      .wdata(line_wdata), .raddr(idx), .rdata(line_rd[w])
    );
    set_array #(.entry_t(stamp_t), .NUM_SETS(NUM_SETS)) u_stamp (
      .clk(clk), .rst(rst), .wen(stamp_wen[w]), .waddr(idx),
      .wdata(lk.stamp), .raddr(idx), .rdata(stamp_rd[w])
    );

    assign way_hit[w]   = meta_rd[w].valid && (meta_rd[w].tag == tag);
    assign line_wen[w]  = (lk.write_hit && (lk.hit_way == WAY_W'(w))) ||
                          (lk.refill_beat && (lk.victim_way == WAY_W'(w)));
    assign stamp_wen[w] = lk.touch && lk.hit && (lk.hit_way == WAY_W'(w));
  end

  // Lowest hitting way wins
  always_comb begin
    hit_idx = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (way_hit[w]) hit_idx = WAY_W'(w);
    end
  end

  // Smallest stamp is the victim, strict compare keeps the lowest index on ties
  always_comb begin
    vic_idx   = '0;
    vic_stamp = stamp_rd[0];
    for (int w = 1; w < NUM_WAYS; w++) begin
      if (stamp_rd[w] < vic_stamp) begin
        vic_idx   = WAY_W'(w);
        vic_stamp = stamp_rd[w];
      end
    end
  end

  // Byte merge of the CPU word into the hit line
  assign old_word    = lk.hit_line[wsel*WORD_W +: WORD_W];
  assign bit_mask    = {{8{req_wstrb[3]}}, {8{req_wstrb[2]}},
                        {8{req_wstrb[1]}}, {8{req_wstrb[0]}}};
  assign merged_word = (old_word & ~bit_mask) | (req_wdata & bit_mask);

  always_comb begin
    merged_line = lk.hit_line;
    merged_line[wsel*WORD_W +: WORD_W] = merged_word;
  end

  // Refill enters at the top, first beat ends in word 0
  assign shifted_line = {lk.refill_data, lk.victim_line[$bits(line_t)-1:WORD_W]};
  assign line_wdata   = lk.write_hit ? merged_line : shifted_line;

  always_comb begin
    meta_wdata = '0;                   // Line stays invalid mid-refill
    if (lk.write_hit) begin
      meta_wdata.valid = 1'b1;
      meta_wdata.dirty = 1'b1;
      meta_wdata.tag   = tag;
    end else if (lk.refill_done) begin
      meta_wdata.valid = 1'b1;         // Clean after refill
      meta_wdata.tag   = tag;
    end
  end

  assign lk.hit          = |way_hit;
  assign lk.hit_way      = hit_idx;
  assign lk.victim_way   = vic_idx;
  assign lk.hit_line     = line_rd[hit_idx];
  assign lk.victim_line  = line_rd[vic_idx];
  assign lk.victim_dirty = meta_rd[vic_idx].dirty;
  assign lk.victim_tag   = meta_rd[vic_idx].tag;

endmodule

`default_nettype wire

// File: hw/set_array.sv
`timescale 1ns/1ps
`default_nettype none

module set_array #(
  parameter type entry_t  = logic,
  parameter int  NUM_SETS = 8
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wen,
  input  dcache_pkg::set_idx_t waddr,
  input  entry_t               wdata,
  input  dcache_pkg::set_idx_t raddr,
  output entry_t               rdata
);

  entry_t mem [NUM_SETS];  // One entry per set

  // Cleared on reset so every line starts invalid with stamp zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        mem[s] <= '0;
      end
    end else if (wen) begin
      mem[waddr] <= wdata;
    end
  end

  assign rdata = mem[raddr];  // Asynchronous read

endmodule

`default_nettype wire

// File: hw/lookup_if.sv
`timescale 1ns/1ps
`default_nettype none

interface lookup_if #(
  parameter int NUM_WAYS = 6
);
  import dcache_pkg::*;

  localparam int WAY_W = $clog2(NUM_WAYS);

  // Lookup results, combinational on the held CPU address
  logic             hit;
  logic [WAY_W-1:0] hit_way;       // Lowest hitting way
  logic [WAY_W-1:0] victim_way;    // Oldest stamp
  logic             victim_dirty;
  tag_t             victim_tag;
  line_t            hit_line;
  line_t            victim_line;

  // Update requests from the FSM
  logic             touch;         // Stamp hit way
  logic             write_hit;     // Merge CPU word, set dirty
  logic             refill_beat;   // Shift one memory word into victim
  logic             refill_done;   // Last beat, line becomes valid and clean
  word_t            refill_data;
  stamp_t           stamp;         // Current LRU time

  modport ways (
    output hit, hit_way, victim_way, victim_dirty, victim_tag, hit_line, victim_line,
    input  touch, write_hit, refill_beat, refill_done, refill_data, stamp
  );

  modport ctrl (
    input  hit, victim_dirty, victim_tag, hit_line, victim_line,
    output touch, write_hit, refill_beat, refill_done, refill_data, stamp
  );

endinterface

`default_nettype wire

// File: hw/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  // Address split is tag | index | offset
  localparam int OFFSET_W   = 5;                   // Byte offset in a 32-byte line
  localparam int INDEX_W    = 3;                   // Set index
  localparam int TAG_W      = 32 - OFFSET_W - INDEX_W;
  localparam int NUM_SETS   = 1 << INDEX_W;
  localparam int LINE_WORDS = 8;                   // Words per line, one per burst beat
  localparam int WORD_SEL_W = $clog2(LINE_WORDS);  // Word offset inside a line

  typedef logic [31:0]          addr_t;
  typedef logic [31:0]          word_t;            // One bus beat
  typedef logic [3:0]           strb_t;
  typedef logic [TAG_W-1:0]     tag_t;
  typedef logic [INDEX_W-1:0]   set_idx_t;
  typedef logic [LINE_WORDS*32-1:0] line_t;        // Word 0 in the low bits
  typedef logic [31:0]          stamp_t;           // LRU timestamp

  // Per way and set state
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } meta_t;

endpackage

`default_nettype wire
